//--- core_pkg.sv
package core_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;

   localparam word_t RESET_PC = 32'hBFC0_0000;
   localparam int    NUM_REGS = 32;

   // Operand forward selects
   localparam logic [1:0] FWD_RF  = 2'd0;
   localparam logic [1:0] FWD_EX  = 2'd1;
   localparam logic [1:0] FWD_MEM = 2'd2;

   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_SB      = 6'h28,
      OP_SW      = 6'h2b
   } opcode_e;

   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_SRA  = 6'h03,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_NOR  = 6'h27,
      FN_SLT  = 6'h2a,
      FN_SLTU = 6'h2b
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_e;

   // Bit 2 set for loads
   typedef enum logic [2:0] {
      MEM_NONE = 3'b000,
      MEM_SW   = 3'b010,
      MEM_SB   = 3'b011,
      MEM_LW   = 3'b100,
      MEM_LB   = 3'b101,
      MEM_LBU  = 3'b110
   } mem_op_e;

endpackage

//--- fetch_stage.sv
module fetch_stage (
   input  logic            clk,
   input  logic            rst,
   input  logic            stall_i,
   output core_pkg::word_t pc_o,
   input  core_pkg::word_t inst_i,
   output core_pkg::word_t id_pc_o,
   output core_pkg::word_t id_inst_o,
   output logic            id_valid_o
);
   import core_pkg::*;

   // PC only steps by four
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_o <= RESET_PC;
      end else if (!stall_i) begin
         pc_o <= pc_o + 32'd4;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         id_valid_o <= 1'b0;
      end else if (!stall_i) begin
         id_valid_o <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall_i) begin
         id_pc_o   <= pc_o;
         id_inst_o <= inst_i;
      end
   end

endmodule

//--- regfile.sv
module regfile (
   input  logic                clk,
   input  logic                rst,
   input  core_pkg::reg_addr_t raddr_a_i,
   input  core_pkg::reg_addr_t raddr_b_i,
   output core_pkg::word_t     rdata_a_o,
   output core_pkg::word_t     rdata_b_o,
   input  logic                wen_i,
   input  core_pkg::reg_addr_t waddr_i,
   input  core_pkg::word_t     wdata_i
);
   import core_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wen_i) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   // Writeback data bypasses the array
   assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                      (wen_i && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
   assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                      (wen_i && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule

//--- hazard_unit.sv
module hazard_unit (
   input  core_pkg::reg_addr_t rs_i,
   input  core_pkg::reg_addr_t rt_i,
   input  core_pkg::reg_addr_t ex_dest_i,
   input  logic                ex_wen_i,
   input  logic                ex_is_load_i,
   input  core_pkg::reg_addr_t mem_dest_i,
   input  logic                mem_wen_i,
   output logic [1:0]          fwd_a_o,
   output logic [1:0]          fwd_b_o,
   output logic                stall_o
);
   import core_pkg::*;

   logic ex_hit_a;
   logic ex_hit_b;
   logic mem_hit_a;
   logic mem_hit_b;

   function automatic logic hit(reg_addr_t src, reg_addr_t dest, logic wen);
      return wen && src != '0 && src == dest;
   endfunction

   assign ex_hit_a  = hit(rs_i, ex_dest_i, ex_wen_i);
   assign ex_hit_b  = hit(rt_i, ex_dest_i, ex_wen_i);
   assign mem_hit_a = hit(rs_i, mem_dest_i, mem_wen_i);
   assign mem_hit_b = hit(rt_i, mem_dest_i, mem_wen_i);

   // Execute holds the younger value
   assign fwd_a_o = ex_hit_a ? FWD_EX : (mem_hit_a ? FWD_MEM : FWD_RF);
   assign fwd_b_o = ex_hit_b ? FWD_EX : (mem_hit_b ? FWD_MEM : FWD_RF);

   // Load data is only ready in memory stage
   assign stall_o = ex_is_load_i && (ex_hit_a || ex_hit_b);

endmodule

//--- id_stage.sv
module id_stage (
   input  logic                clk,
   input  logic                rst,
   input  logic                stall_i,
   input  core_pkg::word_t     pc_i,
   input  core_pkg::word_t     inst_i,
   input  logic                valid_i,
   output core_pkg::reg_addr_t rs_o,
   output core_pkg::reg_addr_t rt_o,
   input  core_pkg::word_t     rdata_a_i,
   input  core_pkg::word_t     rdata_b_i,
   input  logic [1:0]          fwd_a_i,
   input  logic [1:0]          fwd_b_i,
   input  core_pkg::word_t     ex_result_i,
   input  core_pkg::word_t     mem_result_i,
   output core_pkg::word_t     ex_pc_o,
   output core_pkg::alu_op_e   ex_alu_op_o,
   output core_pkg::word_t     ex_src_a_o,
   output core_pkg::word_t     ex_src_b_o,
   output core_pkg::word_t     ex_store_data_o,
   output core_pkg::mem_op_e   ex_mem_op_o,
   output core_pkg::reg_addr_t ex_dest_o,
   output logic                ex_wen_o,
   output logic                ex_valid_o
);
   import core_pkg::*;

   opcode_e opcode;
   funct_e  funct;
   alu_op_e alu_op;
   mem_op_e mem_op;
   word_t   imm_ext;
   word_t   rs_val;
   word_t   rt_val;
   logic    writes;
   logic    is_shift;
   logic    use_imm;
   logic    uses_rt;

   function automatic word_t pick(logic [1:0] sel, word_t rf, word_t ex, word_t mem);
      case (sel)
         FWD_EX:  return ex;
         FWD_MEM: return mem;
         default: return rf;
      endcase
   endfunction

   assign opcode  = opcode_e'(inst_i[31:26]);
   assign funct   = funct_e'(inst_i[5:0]);
   assign use_imm = opcode != OP_SPECIAL;
   assign uses_rt = opcode inside {OP_SPECIAL, OP_SW, OP_SB};

   // Logic immediates are zero extended
   assign imm_ext = (opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) ?
                    {16'b0, inst_i[15:0]} : {{16{inst_i[15]}}, inst_i[15:0]};

   assign rs_o = valid_i ? inst_i[25:21] : '0;
   assign rt_o = (valid_i && uses_rt) ? inst_i[20:16] : '0;

   assign rs_val = pick(fwd_a_i, rdata_a_i, ex_result_i, mem_result_i);
   assign rt_val = pick(fwd_b_i, rdata_b_i, ex_result_i, mem_result_i);

   // Anything undecoded becomes a no-op
   always_comb begin
      alu_op   = ALU_ADD;
      mem_op   = MEM_NONE;
      writes   = 1'b1;
      is_shift = 1'b0;
      case (opcode)
         OP_SPECIAL: begin
            is_shift = funct inside {FN_SLL, FN_SRL, FN_SRA};
            case (funct)
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_NOR:  alu_op = ALU_NOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SLTU: alu_op = ALU_SLTU;
               FN_SLL:  alu_op = ALU_SLL;
               FN_SRL:  alu_op = ALU_SRL;
               FN_SRA:  alu_op = ALU_SRA;
               default: writes = 1'b0;
            endcase
         end
         OP_ADDIU: alu_op = ALU_ADD;
         OP_SLTI:  alu_op = ALU_SLT;
         OP_ANDI:  alu_op = ALU_AND;
         OP_ORI:   alu_op = ALU_OR;
         OP_XORI:  alu_op = ALU_XOR;
         OP_LUI:   alu_op = ALU_LUI;
         OP_LW:    mem_op = MEM_LW;
         OP_LB:    mem_op = MEM_LB;
         OP_LBU:   mem_op = MEM_LBU;
         OP_SW, OP_SB: begin
            mem_op = (opcode == OP_SW) ? MEM_SW : MEM_SB;
            writes = 1'b0;
         end
         default:  writes = 1'b0;
      endcase
   end

   // A stall sends a bubble to execute
   always_ff @(posedge clk) begin
      if (rst || stall_i) begin
         ex_valid_o  <= 1'b0;
         ex_wen_o    <= 1'b0;
         ex_mem_op_o <= MEM_NONE;
      end else begin
         ex_valid_o  <= valid_i;
         ex_wen_o    <= valid_i && writes;
         ex_mem_op_o <= valid_i ? mem_op : MEM_NONE;
      end
   end

   always_ff @(posedge clk) begin
      ex_pc_o         <= pc_i;
      ex_alu_op_o     <= alu_op;
      ex_src_a_o      <= is_shift ? {27'b0, inst_i[10:6]} : rs_val;
      ex_src_b_o      <= use_imm ? imm_ext : rt_val;
      ex_store_data_o <= rt_val;
      ex_dest_o       <= use_imm ? inst_i[20:16] : inst_i[15:11];
   end

endmodule

//--- ex_stage.sv
module ex_stage (
   input  logic                clk,
   input  logic                rst,
   input  core_pkg::alu_op_e   alu_op_i,
   input  core_pkg::word_t     src_a_i,
   input  core_pkg::word_t     src_b_i,
   input  core_pkg::word_t     store_data_i,
   input  core_pkg::mem_op_e   mem_op_i,
   input  core_pkg::reg_addr_t dest_i,
   input  logic                wen_i,
   input  logic                valid_i,
   input  core_pkg::word_t     pc_i,
   output core_pkg::word_t     result_o,
   output core_pkg::word_t     mem_pc_o,
   output core_pkg::word_t     mem_addr_o,
   output core_pkg::word_t     mem_store_data_o,
   output core_pkg::mem_op_e   mem_op_o,
   output core_pkg::reg_addr_t mem_dest_o,
   output logic                mem_wen_o,
   output logic                mem_valid_o
);
   import core_pkg::*;

   logic [4:0] shamt;

   assign shamt = src_a_i[4:0];

   // Loads and stores use the sum as address
   always_comb begin
      case (alu_op_i)
         ALU_ADD:  result_o = src_a_i + src_b_i;
         ALU_SUB:  result_o = src_a_i - src_b_i;
         ALU_AND:  result_o = src_a_i & src_b_i;
         ALU_OR:   result_o = src_a_i | src_b_i;
         ALU_XOR:  result_o = src_a_i ^ src_b_i;
         ALU_NOR:  result_o = ~(src_a_i | src_b_i);
         ALU_SLT:  result_o = {31'b0, $signed(src_a_i) < $signed(src_b_i)};
         ALU_SLTU: result_o = {31'b0, src_a_i < src_b_i};
         ALU_SLL:  result_o = src_b_i << shamt;
         ALU_SRL:  result_o = src_b_i >> shamt;
         ALU_SRA:  result_o = $unsigned($signed(src_b_i) >>> shamt);
         ALU_LUI:  result_o = {src_b_i[15:0], 16'b0};
         default:  result_o = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mem_valid_o <= 1'b0;
         mem_wen_o   <= 1'b0;
         mem_op_o    <= MEM_NONE;
      end else begin
         mem_valid_o <= valid_i;
         mem_wen_o   <= wen_i;
         mem_op_o    <= mem_op_i;
      end
   end

   always_ff @(posedge clk) begin
      mem_pc_o         <= pc_i;
      mem_addr_o       <= result_o;
      mem_store_data_o <= store_data_i;
      mem_dest_o       <= dest_i;
   end

endmodule

//--- mem_stage.sv
module mem_stage (
   input  logic                clk,
   input  logic                rst,
   input  core_pkg::word_t     pc_i,
   input  core_pkg::word_t     addr_i,
   input  core_pkg::word_t     store_data_i,
   input  core_pkg::mem_op_e   mem_op_i,
   input  core_pkg::reg_addr_t dest_i,
   input  logic                wen_i,
   input  logic                valid_i,
   output logic                data_en_o,
   output logic [3:0]          data_wen_o,
   output core_pkg::word_t     data_addr_o,
   output core_pkg::word_t     data_wdata_o,
   input  core_pkg::word_t     data_rdata_i,
   output core_pkg::word_t     result_o,
   output logic                rf_wen_o,
   output core_pkg::reg_addr_t rf_waddr_o,
   output core_pkg::word_t     rf_wdata_o,
   output core_pkg::word_t     wb_pc_o,
   output logic [3:0]          wb_rf_wen_o,
   output core_pkg::reg_addr_t wb_rf_wnum_o,
   output core_pkg::word_t     wb_rf_wdata_o
);
   import core_pkg::*;

   logic [7:0] load_byte;
   logic       is_store;
   logic       wb_wen;
   reg_addr_t  wb_dest;
   word_t      wb_data;

   assign is_store = valid_i && (mem_op_i inside {MEM_SW, MEM_SB});

   assign data_en_o    = valid_i && mem_op_i != MEM_NONE;
   assign data_addr_o  = addr_i;
   assign data_wdata_o = (mem_op_i == MEM_SB) ? {4{store_data_i[7:0]}} : store_data_i;
   // SB enables only the addressed lane
   assign data_wen_o   = !is_store ? 4'b0000 :
                         (mem_op_i == MEM_SW) ? 4'b1111 : 4'b0001 << addr_i[1:0];

   assign load_byte = data_rdata_i[8*addr_i[1:0] +: 8];

   always_comb begin
      case (mem_op_i)
         MEM_LW:  result_o = data_rdata_i;
         MEM_LB:  result_o = {{24{load_byte[7]}}, load_byte};
         MEM_LBU: result_o = {24'b0, load_byte};
         default: result_o = addr_i;
      endcase
   end

   // r0 writes dropped here
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_wen <= 1'b0;
      end else begin
         wb_wen <= valid_i && wen_i && dest_i != '0;
      end
   end

   always_ff @(posedge clk) begin
      wb_pc_o <= pc_i;
      wb_dest <= dest_i;
      wb_data <= result_o;
   end

   assign rf_wen_o      = wb_wen;
   assign rf_waddr_o    = wb_dest;
   assign rf_wdata_o    = wb_data;
   assign wb_rf_wen_o   = {4{wb_wen}};
   assign wb_rf_wnum_o  = wb_dest;
   assign wb_rf_wdata_o = wb_data;

endmodule

//--- mips_core.sv
module mips_core (
   input  logic                clk,
   input  logic                rst,
   output core_pkg::word_t     inst_addr_o,
   input  core_pkg::word_t     inst_data_i,
   output logic                data_en_o,
   output logic [3:0]          data_wen_o,
   output core_pkg::word_t     data_addr_o,
   output core_pkg::word_t     data_wdata_o,
   input  core_pkg::word_t     data_rdata_i,
   output core_pkg::word_t     wb_pc_o,
   output logic [3:0]          wb_rf_wen_o,
   output core_pkg::reg_addr_t wb_rf_wnum_o,
   output core_pkg::word_t     wb_rf_wdata_o
);
   import core_pkg::*;

   logic       stall;
   word_t      id_pc, id_inst;
   logic       id_valid;
   reg_addr_t  rs, rt;
   word_t      rdata_a, rdata_b;
   logic [1:0] fwd_a, fwd_b;

   word_t      ex_pc, ex_src_a, ex_src_b, ex_store_data, ex_result;
   alu_op_e    ex_alu_op;
   mem_op_e    ex_mem_op;
   reg_addr_t  ex_dest;
   logic       ex_wen, ex_valid;

   word_t      mem_pc, mem_addr, mem_store_data, mem_result;
   mem_op_e    mem_op;
   reg_addr_t  mem_dest;
   logic       mem_wen, mem_valid;

   logic       rf_wen;
   reg_addr_t  rf_waddr;
   word_t      rf_wdata;

   fetch_stage u_fetch (
      .clk        (clk),
      .rst        (rst),
      .stall_i    (stall),
      .pc_o       (inst_addr_o),
      .inst_i     (inst_data_i),
      .id_pc_o    (id_pc),
      .id_inst_o  (id_inst),
      .id_valid_o (id_valid)
   );

   id_stage u_decode (
      .clk             (clk),
      .rst             (rst),
      .stall_i         (stall),
      .pc_i            (id_pc),
      .inst_i          (id_inst),
      .valid_i         (id_valid),
      .rs_o            (rs),
      .rt_o            (rt),
      .rdata_a_i       (rdata_a),
      .rdata_b_i       (rdata_b),
      .fwd_a_i         (fwd_a),
      .fwd_b_i         (fwd_b),
      .ex_result_i     (ex_result),
      .mem_result_i    (mem_result),
      .ex_pc_o         (ex_pc),
      .ex_alu_op_o     (ex_alu_op),
      .ex_src_a_o      (ex_src_a),
      .ex_src_b_o      (ex_src_b),
      .ex_store_data_o (ex_store_data),
      .ex_mem_op_o     (ex_mem_op),
      .ex_dest_o       (ex_dest),
      .ex_wen_o        (ex_wen),
      .ex_valid_o      (ex_valid)
   );

   regfile u_regfile (
      .clk       (clk),
      .rst       (rst),
      .raddr_a_i (rs),
      .raddr_b_i (rt),
      .rdata_a_o (rdata_a),
      .rdata_b_o (rdata_b),
      .wen_i     (rf_wen),
      .waddr_i   (rf_waddr),
      .wdata_i   (rf_wdata)
   );

   // Bit 2 of the memory op marks a load
   hazard_unit u_hazard (
      .rs_i         (rs),
      .rt_i         (rt),
      .ex_dest_i    (ex_dest),
      .ex_wen_i     (ex_wen),
      .ex_is_load_i (ex_mem_op[2]),
      .mem_dest_i   (mem_dest),
      .mem_wen_i    (mem_wen),
      .fwd_a_o      (fwd_a),
      .fwd_b_o      (fwd_b),
      .stall_o      (stall)
   );

   ex_stage u_execute (
      .clk              (clk),
      .rst              (rst),
      .alu_op_i         (ex_alu_op),
      .src_a_i          (ex_src_a),
      .src_b_i          (ex_src_b),
      .store_data_i     (ex_store_data),
      .mem_op_i         (ex_mem_op),
      .dest_i           (ex_dest),
      .wen_i            (ex_wen),
      .valid_i          (ex_valid),
      .pc_i             (ex_pc),
      .result_o         (ex_result),
      .mem_pc_o         (mem_pc),
      .mem_addr_o       (mem_addr),
      .mem_store_data_o (mem_store_data),
      .mem_op_o         (mem_op),
      .mem_dest_o       (mem_dest),
      .mem_wen_o        (mem_wen),
      .mem_valid_o      (mem_valid)
   );

   mem_stage u_memory (
      .clk           (clk),
      .rst           (rst),
      .pc_i          (mem_pc),
      .addr_i        (mem_addr),
      .store_data_i  (mem_store_data),
      .mem_op_i      (mem_op),
      .dest_i        (mem_dest),
      .wen_i         (mem_wen),
      .valid_i       (mem_valid),
      .data_en_o     (data_en_o),
      .data_wen_o    (data_wen_o),
      .data_addr_o   (data_addr_o),
      .data_wdata_o  (data_wdata_o),
      .data_rdata_i  (data_rdata_i),
      .result_o      (mem_result),
      .rf_wen_o      (rf_wen),
      .rf_waddr_o    (rf_waddr),
      .rf_wdata_o    (rf_wdata),
      .wb_pc_o       (wb_pc_o),
      .wb_rf_wen_o   (wb_rf_wen_o),
      .wb_rf_wnum_o  (wb_rf_wnum_o),
      .wb_rf_wdata_o (wb_rf_wdata_o)
   );

endmodule

//--- wb_checker.sv
module wb_checker (
   input  logic                clk,
   input  logic                rst,
   input  core_pkg::word_t     wb_pc_i,
   input  logic [3:0]          wb_rf_wen_i,
   input  core_pkg::reg_addr_t wb_rf_wnum_i,
   input  core_pkg::word_t     wb_rf_wdata_i,
   input  logic                data_en_i,
   input  logic [3:0]          data_wen_i,
   input  core_pkg::word_t     data_addr_i,
   input  core_pkg::word_t     data_wdata_i
);
   import core_pkg::*;

   word_t      exp_pc_q[$];
   reg_addr_t  exp_num_q[$];
   word_t      exp_data_q[$];
   word_t      exp_addr_q[$];
   logic [3:0] exp_lanes_q[$];
   word_t      exp_wdata_q[$];

   string test_name;
   int    test_errors;
   int    total_errors;
   int    total_checks;

   initial begin
      test_name    = "none";
      test_errors  = 0;
      total_errors = 0;
      total_checks = 0;
   end

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic expect_write(input word_t pc, input reg_addr_t num, input word_t data);
      exp_pc_q.push_back(pc);
      exp_num_q.push_back(num);
      exp_data_q.push_back(data);
   endtask

   task automatic expect_store(input word_t addr, input logic [3:0] lanes, input word_t data);
      exp_addr_q.push_back(addr);
      exp_lanes_q.push_back(lanes);
      exp_wdata_q.push_back(data);
   endtask

   function automatic int pending();
      return exp_pc_q.size() + exp_addr_q.size();
   endfunction

   task automatic end_test(output int errors);
      if (test_errors == 0) begin
         $display("PASS  %s", test_name);
      end else begin
         $display("FAIL  %s with %0d errors", test_name, test_errors);
      end
      errors = test_errors;
   endtask

   // Registered trace and data port are stable at the falling edge
   always @(negedge clk) begin
      if (rst !== 1'b1 && wb_rf_wen_i !== 4'h0) begin
         total_checks++;
         if (exp_pc_q.size() == 0) begin
            $display("%s: register write to r%0d at pc %h arrived with none expected",
                     test_name, wb_rf_wnum_i, wb_pc_i);
            test_errors++;
            total_errors++;
         end else if (wb_rf_wen_i !== 4'hf || wb_pc_i !== exp_pc_q[0] ||
                      wb_rf_wnum_i !== exp_num_q[0] || wb_rf_wdata_i !== exp_data_q[0]) begin
            $display("FAILED %s: expected pc %h r%0d %h wen %b, actual pc %h r%0d %h wen %b",
                     test_name, exp_pc_q[0], exp_num_q[0], exp_data_q[0], 4'hf,
                     wb_pc_i, wb_rf_wnum_i, wb_rf_wdata_i, wb_rf_wen_i);
            test_errors++;
            total_errors++;
         end
         if (exp_pc_q.size() != 0) begin
            void'(exp_pc_q.pop_front());
            void'(exp_num_q.pop_front());
            void'(exp_data_q.pop_front());
         end
      end
   end

   always @(negedge clk) begin
      if (rst !== 1'b1 && data_en_i === 1'b1 && data_wen_i !== 4'h0) begin
         total_checks++;
         if (exp_addr_q.size() == 0) begin
            $display("%s: store to address %h arrived with none expected",
                     test_name, data_addr_i);
            test_errors++;
            total_errors++;
         end else begin
            if (data_addr_i !== exp_addr_q[0] || data_wen_i !== exp_lanes_q[0] ||
                data_wdata_i !== exp_wdata_q[0]) begin
               $display("FAILED %s: store expected %h lanes %b %h, actual %h lanes %b %h",
                        test_name, exp_addr_q[0], exp_lanes_q[0], exp_wdata_q[0],
                        data_addr_i, data_wen_i, data_wdata_i);
               test_errors++;
               total_errors++;
            end
            void'(exp_addr_q.pop_front());
            void'(exp_lanes_q.pop_front());
            void'(exp_wdata_q.pop_front());
         end
      end
   end

endmodule

//--- tb_mips_core.sv
module tb_mips_core;
   import core_pkg::*;

   localparam int PROG_LEN     = 150;
   localparam int NUM_TESTS    = 6;
   localparam int PERIOD       = 100;
   localparam int WATCH_CYCLES = NUM_TESTS * 2 * (PROG_LEN + 10);

   logic       clk;
   logic       rst;
   word_t      inst_addr;
   word_t      inst_data;
   logic       data_en;
   logic [3:0] data_wen;
   word_t      data_addr;
   word_t      data_wdata;
   word_t      data_rdata;
   word_t      wb_pc;
   logic [3:0] wb_rf_wen;
   reg_addr_t  wb_rf_wnum;
   word_t      wb_rf_wdata;

   word_t       imem [PROG_LEN];
   word_t       dmem [256];
   word_t       inst_idx;
   logic [31:0] lfsr_state;

   mips_core DUT (
      .clk           (clk),
      .rst           (rst),
      .inst_addr_o   (inst_addr),
      .inst_data_i   (inst_data),
      .data_en_o     (data_en),
      .data_wen_o    (data_wen),
      .data_addr_o   (data_addr),
      .data_wdata_o  (data_wdata),
      .data_rdata_i  (data_rdata),
      .wb_pc_o       (wb_pc),
      .wb_rf_wen_o   (wb_rf_wen),
      .wb_rf_wnum_o  (wb_rf_wnum),
      .wb_rf_wdata_o (wb_rf_wdata)
   );

   wb_checker u_checker (
      .clk           (clk),
      .rst           (rst),
      .wb_pc_i       (wb_pc),
      .wb_rf_wen_i   (wb_rf_wen),
      .wb_rf_wnum_i  (wb_rf_wnum),
      .wb_rf_wdata_i (wb_rf_wdata),
      .data_en_i     (data_en),
      .data_wen_i    (data_wen),
      .data_addr_i   (data_addr),
      .data_wdata_i  (data_wdata)
   );

   // Past the program the core fetches zero words
   assign inst_idx   = (inst_addr - RESET_PC) >> 2;
   assign inst_data  = (inst_idx < PROG_LEN) ? imem[inst_idx] : 32'h0;
   assign data_rdata = dmem[data_addr[9:2]];

   always @(posedge clk) begin
      if (rst === 1'b0 && data_en === 1'b1) begin
         for (int b = 0; b < 4; b++) begin
            if (data_wen[b]) begin
               dmem[data_addr[9:2]][8*b +: 8] <= data_wdata[8*b +: 8];
            end
         end
      end
   end

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCH_CYCLES * PERIOD);
      $display("Timeout: expected writeback or store events never arrived");
      $display("TESTS FAILED");
      $finish;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Kinds 0-10 SPECIAL, 11-16 immediate, 17-19 loads, 20-21 stores
   function automatic word_t encode(input int kind, input reg_addr_t a, input reg_addr_t b,
                                    input reg_addr_t d);
      logic [5:0]  code;
      logic [4:0]  sh;
      logic [15:0] imm;
      code = 6'h00;
      sh   = 5'd0;
      case (kind)
         0:  code = 6'h21;
         1:  code = 6'h23;
         2:  code = 6'h24;
         3:  code = 6'h25;
         4:  code = 6'h26;
         5:  code = 6'h27;
         6:  code = 6'h2a;
         7:  code = 6'h2b;
         8:  code = 6'h00;
         9:  code = 6'h02;
         10: code = 6'h03;
         11: code = 6'h09;
         12: code = 6'h0a;
         13: code = 6'h0c;
         14: code = 6'h0d;
         15: code = 6'h0e;
         16: code = 6'h0f;
         17: code = 6'h23;
         18: code = 6'h20;
         19: code = 6'h24;
         20: code = 6'h2b;
         default: code = 6'h28;
      endcase
      if (kind <= 10) begin
         if (kind >= 8) begin
            sh = take_bits(5);
            return {6'h00, 5'd0, b, d, sh, code};
         end
         return {6'h00, a, b, d, 5'd0, code};
      end
      if (kind <= 16) begin
         imm = take_bits(16);
         return {code, (kind == 16) ? 5'd0 : a, d, imm};
      end
      // Base r0, so the offset is the byte address
      imm = (kind == 17 || kind == 20) ? (take_bits(8) << 2) : take_bits(10);
      return {code, 5'd0, (kind >= 20) ? b : d, imm};
   endfunction

   task automatic gen_program(input int test);
      int        kind;
      int        r;
      reg_addr_t a, b, d, d1, d2, ld;
      d1 = 5'd1;
      d2 = 5'd2;
      ld = 5'd1;
      for (int i = 0; i < PROG_LEN; i++) begin
         a    = take_bits(4);
         b    = take_bits(4);
         d    = 1 + take_bits(4) % 15;
         kind = 0;
         case (test)
            1: begin
               if (i < 16) begin
                  kind = i[0] ? 14 : 16;
                  d    = i / 2 + 1;
                  a    = d;
               end else begin
                  kind = (i - 16) % 11;
                  a    = 1 + take_bits(3);
                  b    = 1 + take_bits(3);
                  d    = 9 + take_bits(3) % 7;
               end
            end
            2: kind = 11 + take_bits(3) % 6;
            3: begin
               kind = take_bits(1) ? take_bits(4) % 11 : 11 + take_bits(3) % 5;
               a    = take_bits(1) ? d1 : d2;
               b    = take_bits(1) ? d1 : d2;
            end
            4: begin
               if (!i[0]) begin
                  kind = 17 + take_bits(2) % 3;
                  ld   = d;
               end else begin
                  r    = take_bits(2);
                  kind = (r == 3) ? 20 : (r == 1) ? 11 + take_bits(3) % 5 : take_bits(4) % 11;
                  a    = ld;
                  b    = ld;
               end
            end
            5: begin
               r = take_bits(2);
               case (r)
                  0: begin
                     kind = 14;
                     a    = 5'd0;
                     d    = 1 + take_bits(3);
                  end
                  1: begin
                     kind = 21;
                     b    = 1 + take_bits(3);
                  end
                  2: kind = 18;
                  default: kind = take_bits(1) ? 19 : 17;
               endcase
            end
            default: begin
               kind = take_bits(5) % 22;
               d    = take_bits(4);
            end
         endcase
         imem[i] = encode(kind, a, b, d);
         d2 = d1;
         d1 = d;
      end
   endtask

   task automatic run_model();
      word_t      r [32];
      word_t      m [256];
      word_t      w, a, b, v, se, ze, addr;
      logic [5:0] op, fn;
      reg_addr_t  dest;
      logic [4:0] sh;
      logic       wr;
      for (int k = 0; k < 32; k++) begin
         r[k] = '0;
      end
      for (int k = 0; k < 256; k++) begin
         m[k] = dmem[k];
      end
      for (int i = 0; i < PROG_LEN; i++) begin
         w    = imem[i];
         op   = w[31:26];
         fn   = w[5:0];
         sh   = w[10:6];
         a    = r[w[25:21]];
         b    = r[w[20:16]];
         se   = {{16{w[15]}}, w[15:0]};
         ze   = {16'b0, w[15:0]};
         addr = a + se;
         dest = w[20:16];
         wr   = 1'b1;
         v    = '0;
         case (op)
            6'h00: begin
               dest = w[15:11];
               case (fn)
                  6'h21: v = a + b;
                  6'h23: v = a - b;
                  6'h24: v = a & b;
                  6'h25: v = a | b;
                  6'h26: v = a ^ b;
                  6'h27: v = ~(a | b);
                  6'h2a: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  6'h2b: v = (a < b) ? 32'd1 : 32'd0;
                  6'h00: v = b << sh;
                  6'h02: v = b >> sh;
                  6'h03: v = $signed(b) >>> sh;
                  default: wr = 1'b0;
               endcase
            end
            6'h09: v = a + se;
            6'h0a: v = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            6'h0c: v = a & ze;
            6'h0d: v = a | ze;
            6'h0e: v = a ^ ze;
            6'h0f: v = {w[15:0], 16'h0};
            6'h23: v = m[addr[9:2]];
            6'h20: begin
               v = m[addr[9:2]] >> (8 * addr[1:0]);
               v = {{24{v[7]}}, v[7:0]};
            end
            6'h24: begin
               v = m[addr[9:2]] >> (8 * addr[1:0]);
               v = {24'b0, v[7:0]};
            end
            6'h2b: begin
               wr = 1'b0;
               m[addr[9:2]] = b;
               u_checker.expect_store(addr, 4'hf, b);
            end
            6'h28: begin
               wr = 1'b0;
               m[addr[9:2]][8*addr[1:0] +: 8] = b[7:0];
               u_checker.expect_store(addr, 4'b0001 << addr[1:0], {4{b[7:0]}});
            end
            default: wr = 1'b0;
         endcase
         if (wr && dest != 5'd0) begin
            r[dest] = v;
            u_checker.expect_write(RESET_PC + 32'(4 * i), dest, v);
         end
      end
   endtask

   initial begin
      string names [NUM_TESTS];
      int    errors;
      int    failed;
      names[0]   = "reg_alu";
      names[1]   = "immediate";
      names[2]   = "forwarding";
      names[3]   = "load_use";
      names[4]   = "byte_access";
      names[5]   = "mixed_random";
      failed     = 0;
      rst        = 1'b1;
      lfsr_state = 32'h0c70_93f4;
      for (int t = 1; t <= NUM_TESTS; t++) begin
         @(posedge clk);
         #10;
         rst = 1'b1;
         gen_program(t);
         for (int k = 0; k < 256; k++) begin
            dmem[k] = take_bits(32);
         end
         u_checker.begin_test(names[t-1]);
         run_model();
         repeat (3) @(posedge clk);
         #10;
         rst = 1'b0;
         while (u_checker.pending() != 0) begin
            @(posedge clk);
         end
         // Late extra events still reach the checker
         repeat (5) @(posedge clk);
         u_checker.end_test(errors);
         if (errors != 0) begin
            failed++;
         end
      end
      $display("Tests: %0d, passed: %0d, failed: %0d, checks: %0d, errors: %0d",
               NUM_TESTS, NUM_TESTS - failed, failed, u_checker.total_checks,
               u_checker.total_errors);
      if (failed == 0 && u_checker.total_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
core_pkg.sv
fetch_stage.sv
regfile.sv
hazard_unit.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
mips_core.sv
wb_checker.sv
tb_mips_core.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - core_pkg.sv
  - fetch_stage.sv
  - regfile.sv
  - hazard_unit.sv
  - id_stage.sv
  - ex_stage.sv
  - mem_stage.sv
  - mips_core.sv
  - target: test
    files:
      - wb_checker.sv
      - tb_mips_core.sv
